//--- test/decode_stim.txt
# name instr available fault imm rd_rf ex_alu ma_mem wb_rf mux_sel (all hex)
# rd_rf={en,rs1,rs2} ex_alu={en,br,alt,f3} ma_mem={en,st,f3} wb_rf={en,1,rd,0} mux={a,b,wb,pc}
add_x3_x1_x2      002081B3 1 0 00000002 112 20 00 330 00
sub_x5_x6_x7      407302B3 1 0 00000407 167 28 00 350 00
srai_x4_x4_3      40325213 1 0 00000403 143 2D 05 340 10
lw_x8_m4_x2       FFC12403 1 0 FFFFFFFC 12C 20 12 380 18
sw_x9_8_x10       00952423 1 0 00000008 1A9 20 1A 180 10
lui_x7            123453B7 1 0 12345000 083 00 05 370 14
auipc_x1          FFFFF097 1 0 FFFFF000 0FF 20 07 310 30
jal_x1_16         010000EF 1 0 00000010 000 00 00 310 1E
jalr_x0_x1        00008067 1 0 00000000 110 20 00 300 1D
beq_x1_x2_m8      FE208CE3 1 0 FFFFFFF8 112 30 00 190 03
fence             0FF0000F 1 0 000000FF 00F 00 00 100 10
fence_i           0000100F 1 0 00000000 000 00 01 100 10
bad_rd_x16        00208833 1 1 00000002 012 00 00 100 00
bad_rs1_x17       002881B3 1 1 00000002 012 00 00 130 00
bad_store_rs2_x16 01052423 1 1 00000008 0A0 00 0A 180 10
bad_load_funct3   FFC13403 1 1 FFFFFFFC 02C 00 03 180 18
bad_store_funct3  00953423 1 1 00000008 0A9 00 0B 180 10
bad_jalr_funct3   00009067 1 1 00000000 010 00 01 100 1D
bad_branch_funct3 FE20ACE3 1 1 FFFFFFF8 012 12 02 190 03
bad_op_alt_sll    402091B3 1 1 00000402 012 01 01 130 00
bad_op_funct7_mul 022081B3 1 1 00000022 012 00 00 130 00
bad_opimm_slli    40321213 1 1 00000403 043 01 01 140 10
bad_fence_rd      0FF0008F 1 1 000000FF 00F 00 00 110 10
bad_fence_i_rs2   0010100F 1 1 00000001 001 00 01 100 10
system_ecall      00000073 1 1 00000000 000 00 00 100 10
idle_after_fault  002081B3 0 0 00000000 000 00 00 100 10
bad_low_bits      002081B1 1 1 00000002 012 00 00 130 10
add_after_fault   002081B3 1 0 00000002 112 20 00 330 00
idle_after_add    00000073 0 0 00000002 112 20 00 330 00

//--- flist.f
common/rv32_decode_pkg.sv
verilog/opcode_classify.sv
verilog/field_check.sv
verilog/imm_gen.sv
verilog/microcode_issue.sv
verilog/rv32_decoder.sv
test/rv32_decoder_properties.sv
test/rv32_decoder_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module rv32_decoder_tb \
    -o rv32_decoder_sim

output=$(./obj_dir/rv32_decoder_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- test/rv32_decoder_tb.sv
/*
 * Testbench for the registered RV32I decoder, driven from the stim file.
 * Each line is issued on one edge and its outputs are checked one edge later.
 */
`timescale 1ns/1ps

module rv32_decoder_tb;
    import rv32_decode_pkg::*;

    localparam int    MAX_TESTS = 64;
    localparam string STIM_FILE = "test/decode_stim.txt";

    logic        clk;
    logic        reset_n;
    logic        available;
    instr_word_t instr;
    decode_out_t decoded;
    logic        fault;

    string       names [MAX_TESTS];
    logic [31:0] stim_instr [MAX_TESTS];
    logic [31:0] stim_avail [MAX_TESTS];
    logic [31:0] exp_fault [MAX_TESTS];
    logic [31:0] exp_imm [MAX_TESTS];
    logic [31:0] exp_rd_rf [MAX_TESTS];
    logic [31:0] exp_ex_alu [MAX_TESTS];
    logic [31:0] exp_ma_mem [MAX_TESTS];
    logic [31:0] exp_wb_rf [MAX_TESTS];
    logic [31:0] exp_mux_sel [MAX_TESTS];

    int num_tests = 0;
    bit stim_ok = 1'b1;
    int error_count = 0;
    int pass_count = 0;
    int fail_count = 0;
    int cycle_count = 0;
    int cycle_limit = 1000; // Replaced once the stim file is read

    rv32_decoder dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .available (available),
        .instr     (instr),
        .decoded   (decoded),
        .fault     (fault)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: no result after %0d clock cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic load_stim();
        int          fd;
        int          code;
        bit          done;
        string       tok;
        string       rest;
        logic [31:0] f_instr;
        logic [31:0] f_avail;
        logic [31:0] f_fault;
        logic [31:0] f_imm;
        logic [31:0] f_rd_rf;
        logic [31:0] f_ex_alu;
        logic [31:0] f_ma_mem;
        logic [31:0] f_wb_rf;
        logic [31:0] f_mux_sel;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            stim_ok = 1'b0;
            return;
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok.substr(0, 0) == "#") begin
                code = $fgets(rest, fd); // Column description
            end else if (num_tests >= MAX_TESTS) begin
                $display("Too many tests in %s, the limit is %0d", STIM_FILE, MAX_TESTS);
                stim_ok = 1'b0;
                done = 1'b1;
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", f_instr, f_avail, f_fault,
                    f_imm, f_rd_rf, f_ex_alu, f_ma_mem, f_wb_rf, f_mux_sel);
                if (code != 9) begin
                    $display("Stimulus line for test %s is incomplete", tok);
                    stim_ok = 1'b0;
                    done = 1'b1;
                end else begin
                    names[num_tests] = tok;
                    stim_instr[num_tests] = f_instr;
                    stim_avail[num_tests] = f_avail;
                    exp_fault[num_tests] = f_fault;
                    exp_imm[num_tests] = f_imm;
                    exp_rd_rf[num_tests] = f_rd_rf;
                    exp_ex_alu[num_tests] = f_ex_alu;
                    exp_ma_mem[num_tests] = f_ma_mem;
                    exp_wb_rf[num_tests] = f_wb_rf;
                    exp_mux_sel[num_tests] = f_mux_sel;
                    num_tests++;
                end
            end
        end
        $fclose(fd);
        if (num_tests == 0) begin
            $display("The stimulus file %s holds no tests", STIM_FILE);
            stim_ok = 1'b0;
        end
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s %s: expected %h, actual %h", test, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string test, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("%s: ok", test);
        end else begin
            fail_count++;
            $display("%s: mismatch", test);
        end
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        check_value("reset", "fault", 32'd0, {31'd0, fault});
        check_value("reset", "rd_rf.enable", 32'd0, {31'd0, decoded.rd_rf.enable});
        check_value("reset", "ex_alu.enable", 32'd0, {31'd0, decoded.ex_alu.enable});
        check_value("reset", "ma_mem.enable", 32'd0, {31'd0, decoded.ma_mem.enable});
        check_value("reset", "wb_rf.enable", 32'd0, {31'd0, decoded.wb_rf.enable});
        report_test("reset", errors_before);
    endtask

    task automatic check_outputs(input int idx);
        int errors_before;
        errors_before = error_count;
        check_value(names[idx], "fault", exp_fault[idx], {31'd0, fault});
        check_value(names[idx], "imm", exp_imm[idx], decoded.imm);
        check_value(names[idx], "rd_rf", exp_rd_rf[idx], {23'd0, decoded.rd_rf});
        check_value(names[idx], "ex_alu", exp_ex_alu[idx], {26'd0, decoded.ex_alu});
        check_value(names[idx], "ma_mem", exp_ma_mem[idx], {27'd0, decoded.ma_mem});
        check_value(names[idx], "wb_rf", exp_wb_rf[idx], {22'd0, decoded.wb_rf});
        check_value(names[idx], "mux_sel", exp_mux_sel[idx], {26'd0, decoded.mux_sel});
        report_test(names[idx], errors_before);
    endtask

    initial begin
        reset_n = 1'b0;
        available = 1'b0;
        instr = '0;
        load_stim();
        cycle_limit = (num_tests + 8) * 4;
        if (!stim_ok) begin
            $display("No tests were run because the stimulus could not be read");
        end else begin
            repeat (8) @(posedge clk);
            reset_n <= 1'b1;
            @(negedge clk);
            check_reset_state();
            // Line i goes in at edge i and is checked after edge i+1
            for (int i = 0; i <= num_tests; i++) begin
                @(posedge clk);
                if (i < num_tests) begin
                    instr <= stim_instr[i];
                    available <= stim_avail[i][0];
                end else begin
                    available <= 1'b0;
                end
                @(negedge clk);
                if (i > 0) begin
                    check_outputs(i - 1);
                end
            end
        end
        if (dut.u_properties.failure_count != 0) begin
            $display("Bound property checks failed %0d times", dut.u_properties.failure_count);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d",
            pass_count + fail_count, pass_count, fail_count);
        if (stim_ok && fail_count == 0 && dut.u_properties.failure_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- test/rv32_decoder_properties.sv
/*
 * Concurrent checks on the decoder outputs, bound into rv32_decoder.
 * Covers fault clearing on idle cycles, fault gating and reset values.
 */
`timescale 1ns/1ps

module rv32_decoder_properties (
    input                                clk,
    input                                reset_n,
    input                                available,
    input  rv32_decode_pkg::decode_out_t decoded,
    input  logic                         fault
);
    import rv32_decode_pkg::*;

    logic any_enable;
    int   failure_count = 0;

    assign any_enable = decoded.rd_rf.enable | decoded.ex_alu.enable |
        decoded.ma_mem.enable | decoded.wb_rf.enable;

    property fault_clears_when_idle;
        @(posedge clk) disable iff (!reset_n)
            !available |=> !fault;
    endproperty

    property fault_gates_enables;
        @(posedge clk) disable iff (!reset_n)
            fault |-> !any_enable;
    endproperty

    // Reset is synchronous, so the clear shows one edge later
    property reset_clears_outputs;
        @(posedge clk) !reset_n |=> (!fault && !any_enable);
    endproperty

    a_fault_clears_when_idle: assert property (fault_clears_when_idle)
        else begin
            failure_count = failure_count + 1;
            $error("fault still high one cycle after an idle strobe");
        end

    a_fault_gates_enables: assert property (fault_gates_enables)
        else begin
            failure_count = failure_count + 1;
            $error("micro-op enable set together with fault");
        end

    a_reset_clears_outputs: assert property (reset_clears_outputs)
        else begin
            failure_count = failure_count + 1;
            $error("fault or a micro-op enable not cleared by reset");
        end

endmodule

bind rv32_decoder rv32_decoder_properties u_properties (
    .clk       (clk),
    .reset_n   (reset_n),
    .available (available),
    .decoded   (decoded),
    .fault     (fault)
);

//--- verilog/rv32_decoder.sv
/*
 * Top level of the registered RV32I (16-register) decoder.
 * One instruction per strobed edge, results one cycle later.
 */
`timescale 1ns/1ps

module rv32_decoder (
    input                                clk,
    input                                reset_n,
    input                                available,
    input  rv32_decode_pkg::instr_word_t instr,
    output rv32_decode_pkg::decode_out_t decoded,
    output logic                         fault
);
    import rv32_decode_pkg::*;

    opcode_class_t op_class;
    rf_use_t       rf_use;
    logic          illegal;
    word_t         imm;

    opcode_classify u_classify (
        .instr    (instr),
        .op_class (op_class)
    );

    field_check u_check (
        .instr    (instr),
        .op_class (op_class),
        .rf_use   (rf_use),
        .illegal  (illegal)
    );

    imm_gen u_imm (
        .instr    (instr),
        .op_class (op_class),
        .imm      (imm)
    );

    microcode_issue u_issue (
        .clk       (clk),
        .reset_n   (reset_n),
        .available (available),
        .instr     (instr),
        .op_class  (op_class),
        .rf_use    (rf_use),
        .illegal   (illegal),
        .imm       (imm),
        .decoded   (decoded),
        .fault     (fault)
    );

endmodule

//--- verilog/microcode_issue.sv
/*
 * Forms the per-stage micro-ops and mux selects and registers them.
 * Loads on available; a low strobe clears fault and holds the rest.
 */
`timescale 1ns/1ps

module microcode_issue (
    input                                  clk,
    input                                  reset_n,
    input                                  available,
    input  rv32_decode_pkg::instr_word_t   instr,
    input  rv32_decode_pkg::opcode_class_t op_class,
    input  rv32_decode_pkg::rf_use_t       rf_use,
    input                                  illegal,
    input  rv32_decode_pkg::word_t         imm,
    output rv32_decode_pkg::decode_out_t   decoded,
    output logic                           fault
);
    import rv32_decode_pkg::*;

    decode_out_t next;
    logic [2:0]  funct3;
    logic        uses_funct3;

    assign funct3 = instr.r.funct3;
    assign uses_funct3 = op_class.op | op_class.opimm | op_class.branch;

    always_comb begin
        next.imm = imm;

        next.rd_rf.enable = rf_use.reads_rs & ~illegal;
        next.rd_rf.rs1 = instr.r.rs1[3:0];
        next.rd_rf.rs2 = instr.r.rs2[3:0];

        next.ex_alu.enable = ~illegal & (op_class.op | op_class.opimm | op_class.branch |
            op_class.load | op_class.store | op_class.auipc | op_class.jalr);
        next.ex_alu.is_branch = op_class.branch;
        next.ex_alu.alt_op = instr.r.funct7[5] &
            ((op_class.op & (funct3 == 3'd0 || funct3 == 3'd5)) |
             (op_class.opimm & (funct3 == 3'd5)));
        next.ex_alu.funct3 = uses_funct3 ? funct3 : 3'd0; // Loads, stores and jumps just add

        next.ma_mem.enable = ~illegal & (op_class.load | op_class.store);
        next.ma_mem.is_store = op_class.store;
        next.ma_mem.funct3 = funct3;

        next.wb_rf.enable = rf_use.writes_rd & ~illegal;
        next.wb_rf.valid = 1'b1;
        next.wb_rf.rd = instr.u.rd[3:0];
        next.wb_rf.pad = 4'd0;

        next.mux_sel.alu_a_pc = op_class.auipc;
        next.mux_sel.alu_b_imm = ~(op_class.op | op_class.branch);

        if (op_class.load) begin
            next.mux_sel.wb_sel = WB_SEL_MEM;
        end else if (op_class.jal || op_class.jalr) begin
            next.mux_sel.wb_sel = WB_SEL_NPC; // Link address
        end else if (op_class.lui) begin
            next.mux_sel.wb_sel = WB_SEL_IMM;
        end else begin
            next.mux_sel.wb_sel = WB_SEL_ALU;
        end

        if (op_class.jalr) begin
            next.mux_sel.pc_sel = PC_SEL_REG;
        end else if (op_class.jal) begin
            next.mux_sel.pc_sel = PC_SEL_JUMP;
        end else if (op_class.branch) begin
            next.mux_sel.pc_sel = PC_SEL_BRANCH;
        end else begin
            next.mux_sel.pc_sel = PC_SEL_NPC;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            fault <= 1'b0;
            decoded.rd_rf.enable <= 1'b0;
            decoded.ex_alu.enable <= 1'b0;
            decoded.ma_mem.enable <= 1'b0;
            decoded.wb_rf.enable <= 1'b0;
        end else if (available) begin
            decoded <= next;
            fault <= illegal;
        end else begin
            fault <= 1'b0; // Fault is a one-cycle pulse
        end
    end

endmodule

//--- verilog/imm_gen.sv
/*
 * Builds the 32-bit immediate from the instruction word.
 * Format is picked from the opcode class; I format is the fallback.
 */
`timescale 1ns/1ps

module imm_gen (
    input  rv32_decode_pkg::instr_word_t   instr,
    input  rv32_decode_pkg::opcode_class_t op_class,
    output rv32_decode_pkg::word_t         imm
);

    logic [6:0]  funct7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [19:0] sign_fill;

    assign funct7 = instr.r.funct7;
    assign rs2 = instr.r.rs2;
    assign rs1 = instr.r.rs1;
    assign funct3 = instr.r.funct3;
    assign rd = instr.r.rd;
    assign sign_fill = {20{funct7[6]}}; // instr[31]

    always_comb begin
        if (op_class.lui || op_class.auipc) begin
            imm = {instr.u.upper, 12'b0};
        end else if (op_class.jal) begin
            imm = {sign_fill[11:0], rs1, funct3, rs2[0], funct7[5:0], rs2[4:1], 1'b0};
        end else if (op_class.branch) begin
            imm = {sign_fill, rd[0], funct7[5:0], rd[4:1], 1'b0};
        end else if (op_class.store) begin
            imm = {sign_fill, funct7, rd};
        end else begin
            imm = {sign_fill, funct7, rs2};
        end
    end

endmodule

//--- verilog/field_check.sv
/*
 * Field legality checks for each instruction class, plus register-file use.
 * Every illegal-encoding condition of the decoder is evaluated here.
 */
`timescale 1ns/1ps

module field_check (
    input  rv32_decode_pkg::instr_word_t   instr,
    input  rv32_decode_pkg::opcode_class_t op_class,
    output rv32_decode_pkg::rf_use_t       rf_use,
    output logic                           illegal
);
    import rv32_decode_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic       is_shift;
    logic       bad_rs;
    logic       bad_rd;
    logic       bad_funct3;
    logic       bad_funct7;
    logic       bad_fence;

    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd = instr.u.rd;

    assign rf_use.reads_rs = ~(op_class.lui | op_class.auipc | op_class.jal | op_class.fence);
    assign rf_use.writes_rd = ~(op_class.store | op_class.branch | op_class.fence);

    // Only x0..x15 exist
    assign bad_rs = (rf_use.reads_rs & rs1[4]) |
        ((op_class.op | op_class.store | op_class.branch) & rs2[4]);
    assign bad_rd = rf_use.writes_rd & rd[4];

    always_comb begin
        bad_funct3 = 1'b0;
        if (op_class.store && funct3 >= 3'd3) begin
            bad_funct3 = 1'b1;
        end
        if (op_class.jalr && funct3 != 3'd0) begin
            bad_funct3 = 1'b1;
        end
        if (op_class.load && (funct3 == 3'd3 || funct3 == 3'd6 || funct3 == 3'd7)) begin
            bad_funct3 = 1'b1;
        end
        if (op_class.branch && (funct3 == 3'd2 || funct3 == 3'd3)) begin
            bad_funct3 = 1'b1;
        end
        if (op_class.fence && funct3 > 3'd1) begin
            bad_funct3 = 1'b1;
        end
    end

    assign is_shift = (funct3 == 3'd1) || (funct3 == 3'd5);

    always_comb begin
        bad_funct7 = 1'b0;
        if (op_class.op && funct7 != 7'd0) begin
            // Alternate encoding only for SUB and SRA
            bad_funct7 = !(funct7 == FUNCT7_ALT && (funct3 == 3'd0 || funct3 == 3'd5));
        end
        if (op_class.opimm && is_shift && funct7 != 7'd0) begin
            bad_funct7 = !(funct7 == FUNCT7_ALT && funct3 == 3'd5); // SRAI only
        end
    end

    // FENCE.I additionally needs rs2 and funct7 clear
    assign bad_fence = op_class.fence & ((rs1 != 5'd0) | (rd != 5'd0) | (funct7[6:3] != 4'd0) |
        (funct3[0] & ((rs2 != 5'd0) | (funct7 != 7'd0))));

    assign illegal = op_class.illegal_opcode | bad_rs | bad_rd | bad_funct3 | bad_funct7 |
        bad_fence;

endmodule

//--- verilog/opcode_classify.sv
/*
 * Sorts the major opcode into one-hot instruction classes.
 * Anything unknown, compressed or SYSTEM raises illegal_opcode.
 */
`timescale 1ns/1ps

module opcode_classify (
    input  rv32_decode_pkg::instr_word_t   instr,
    output rv32_decode_pkg::opcode_class_t op_class
);
    import rv32_decode_pkg::*;

    logic [6:0] opcode;

    assign opcode = instr.r.opcode;

    always_comb begin
        op_class = '0;
        case (opcode)
            OPCODE_OP: begin
                op_class.op = 1'b1;
            end
            OPCODE_OPIMM: begin
                op_class.opimm = 1'b1;
            end
            OPCODE_LOAD: begin
                op_class.load = 1'b1;
            end
            OPCODE_STORE: begin
                op_class.store = 1'b1;
            end
            OPCODE_AUIPC: begin
                op_class.auipc = 1'b1;
            end
            OPCODE_BRANCH: begin
                op_class.branch = 1'b1;
            end
            OPCODE_JAL: begin
                op_class.jal = 1'b1;
            end
            OPCODE_JALR: begin
                op_class.jalr = 1'b1;
            end
            OPCODE_LUI: begin
                op_class.lui = 1'b1;
            end
            OPCODE_FENCE: begin
                op_class.fence = 1'b1;
            end
            OPCODE_SYSTEM: begin
                op_class.illegal_opcode = 1'b1; // No CSR or trap support
            end
            default: begin
                op_class.illegal_opcode = 1'b1; // Includes compressed encodings
            end
        endcase
    end

endmodule

//--- common/rv32_decode_pkg.sv
/*
 * Shared types and encodings for the RV32I (16-register) instruction decoder.
 * Imported by every decoder block and visible to the testbench.
 */
package rv32_decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [19:0] upper;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_view_t;

    // Same 32-bit word seen as R-type fields or as U-type fields
    typedef union packed {
        r_view_t r;
        u_view_t u;
    } instr_word_t;

    typedef struct packed {
        logic op;
        logic opimm;
        logic load;
        logic store;
        logic auipc;
        logic branch;
        logic jal;
        logic jalr;
        logic lui;
        logic fence;          // FENCE and FENCE.I
        logic illegal_opcode;
    } opcode_class_t;

    typedef struct packed {
        logic reads_rs;
        logic writes_rd;
    } rf_use_t;

    typedef struct packed {
        logic     enable;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } rd_rf_uop_t;

    typedef struct packed {
        logic       enable;
        logic       is_branch;
        logic       alt_op;   // SUB / SRA select
        logic [2:0] funct3;
    } ex_alu_uop_t;

    typedef struct packed {
        logic       enable;
        logic       is_store;
        logic [2:0] funct3;   // Access size and sign
    } ma_mem_uop_t;

    typedef struct packed {
        logic       enable;
        logic       valid;
        reg_idx_t   rd;
        logic [3:0] pad;
    } wb_rf_uop_t;

    typedef struct packed {
        logic       alu_a_pc;
        logic       alu_b_imm;
        logic [1:0] wb_sel;
        logic [1:0] pc_sel;
    } mux_sel_t;

    typedef struct packed {
        word_t       imm;
        rd_rf_uop_t  rd_rf;
        ex_alu_uop_t ex_alu;
        ma_mem_uop_t ma_mem;
        wb_rf_uop_t  wb_rf;
        mux_sel_t    mux_sel;
    } decode_out_t;

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_FENCE  = 7'b0001111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    localparam logic [6:0] FUNCT7_ALT = 7'h20; // SUB, SRA, SRAI

    localparam logic [1:0] WB_SEL_ALU = 2'd0;
    localparam logic [1:0] WB_SEL_IMM = 2'd1;
    localparam logic [1:0] WB_SEL_MEM = 2'd2;
    localparam logic [1:0] WB_SEL_NPC = 2'd3;

    localparam logic [1:0] PC_SEL_NPC    = 2'd0;
    localparam logic [1:0] PC_SEL_REG    = 2'd1;
    localparam logic [1:0] PC_SEL_JUMP   = 2'd2;
    localparam logic [1:0] PC_SEL_BRANCH = 2'd3;

endpackage
